/* Makefile */
# Verilator build and run of the peripheral wrapper testbench
VERILATOR ?= verilator
TOP       ?= tb_tqv_peripherals
FILELIST  ?= filelist.f
TRACE     ?= periph_trace.txt
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS := $(wildcard *.sv *.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the trace and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST TRACE LOG BUILD_DIR VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM) $(TRACE)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Result: failed"; exit 1; \
	elif ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "Result: no pass line in $(LOG)"; exit 1; \
	else \
		echo "Result: passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* byte_reg_peri.sv */
`timescale 1ns/1ps
// Example byte peripheral, four 8-bit registers at offsets 0..3
// Any write size stores only the low data byte, reads are always ready

module byte_reg_peri (
    input  logic                  clk,
    input  logic                  rst_n,
    output tqv_periph_pkg::pins_t o_pins,
    periph_bus_if.peri            bus
);
    import tqv_periph_pkg::*;

    pins_t      regs [4];
    logic [1:0] idx;

    assign idx = bus.offs[1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (bus.wr_size != ACC_NONE) begin
            regs[idx] <= bus.wdata[7:0];
        end
    end

    assign bus.rdata    = data_t'(regs[idx]);
    assign bus.rd_ready = 1'b1;
    assign o_pins       = regs[0];

endmodule

/* filelist.f */
+incdir+.
tqv_periph_pkg.sv
periph_bus_if.sv
periph_addr_decode.sv
gpio_func_ctrl.sv
word_scratch_peri.sv
byte_reg_peri.sv
read_data_buffer.sv
tqv_peripherals.sv
tb_tqv_peripherals.sv

/* gpio_func_ctrl.sv */
`timescale 1ns/1ps
// GPIO output register, input readback and per-pin output function select
// Selects decode only user slots 1 and 4 and simple slot 0, others drive 0
// Every pin resets onto the GPIO output register

`include "tqv_periph_cfg.svh"

module gpio_func_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  tqv_periph_pkg::pins_t i_ui_in,
    input  tqv_periph_pkg::pins_t i_word_pins,
    input  tqv_periph_pkg::pins_t i_byte_pins,
    output tqv_periph_pkg::pins_t o_uo_out,
    periph_bus_if.peri            bus
);
    import tqv_periph_pkg::*;

    localparam int PIN_IDX_W = $clog2(`TQV_PINS);
    localparam func_sel_t FUNC_GPIO = func_sel_t'(`TQV_SLOT_GPIO);
    localparam func_sel_t FUNC_WORD = func_sel_t'(`TQV_SLOT_WORD);
    localparam func_sel_t FUNC_BYTE =
        func_sel_t'((1 << `TQV_FUNC_SIMPLE_BIT) | `TQV_SLOT_BYTE);

    pins_t                gpio_out;
    func_sel_t            func_sel [`TQV_PINS];
    logic                 wr_en;
    offs_t                sel_rel;
    logic                 sel_hit;
    logic [PIN_IDX_W-1:0] sel_idx;

    assign wr_en = bus.wr_size != ACC_NONE;

    // Pin n select lives at SEL_BASE + 4n, word aligned
    assign sel_rel = bus.offs - offs_t'(`TQV_GPIO_SEL_BASE);
    assign sel_hit = (bus.offs >= offs_t'(`TQV_GPIO_SEL_BASE)) && (sel_rel[1:0] == 2'b00);
    assign sel_idx = sel_rel[PIN_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int i = 0; i < `TQV_PINS; i++) begin
                func_sel[i] <= FUNC_GPIO;
            end
        end else if (wr_en) begin
            if (bus.offs == offs_t'(`TQV_GPIO_OUT_OFFS)) begin
                gpio_out <= bus.wdata[`TQV_PINS-1:0];
            end
            if (sel_hit) begin
                func_sel[sel_idx] <= bus.wdata[`TQV_FUNC_SIMPLE_BIT:0];
            end
        end
    end

    always_comb begin
        bus.rdata = '0;
        if (bus.offs == offs_t'(`TQV_GPIO_OUT_OFFS)) begin
            bus.rdata = data_t'(gpio_out);
        end else if (bus.offs == offs_t'(`TQV_GPIO_IN_OFFS)) begin
            bus.rdata = data_t'(i_ui_in);
        end else if (sel_hit) begin
            bus.rdata = data_t'(func_sel[sel_idx]);
        end
    end

    assign bus.rd_ready = 1'b1;

    // Each pin takes its own bit from the chosen source
    always_comb begin
        for (int n = 0; n < `TQV_PINS; n++) begin
            case (func_sel[n])
                FUNC_GPIO: o_uo_out[n] = gpio_out[n];
                FUNC_WORD: o_uo_out[n] = i_word_pins[n];
                FUNC_BYTE: o_uo_out[n] = i_byte_pins[n];
                default:   o_uo_out[n] = 1'b0;
            endcase
        end
    end

endmodule

/* periph_addr_decode.sv */
`timescale 1ns/1ps
// Purely combinational slot decode for the 11-bit peripheral window
// Empty slots read zero with ready high so a stray read never hangs

`include "tqv_periph_cfg.svh"

module periph_addr_decode (
    input  tqv_periph_pkg::addr_t     i_addr,
    input  tqv_periph_pkg::data_t     i_data_in,
    input  tqv_periph_pkg::acc_size_e i_wr_size,
    input  tqv_periph_pkg::acc_size_e i_rd_size,
    input  logic                      i_rd_block,
    output tqv_periph_pkg::data_t     o_rdata,
    output logic                      o_rd_ready,
    periph_bus_if.ctrl                gpio_bus,
    periph_bus_if.ctrl                word_bus,
    periph_bus_if.ctrl                byte_bus
);
    import tqv_periph_pkg::*;

    logic      byte_space;
    slot_t     user_slot;
    slot_t     simple_slot;
    logic      sel_gpio;
    logic      sel_word;
    logic      sel_byte;
    acc_size_e rd_req;
    offs_t     offs;

    // Bit 10 is the byte space, bits 9:6 the user slot, bits 7:4 the simple slot
    assign byte_space  = i_addr[`TQV_ADDR_W-1];
    assign user_slot   = i_addr[9:6];
    assign simple_slot = i_addr[7:4];
    assign offs        = i_addr[`TQV_OFFS_W-1:0];

    assign sel_gpio = !byte_space && (user_slot == slot_t'(`TQV_SLOT_GPIO));
    assign sel_word = !byte_space && (user_slot == slot_t'(`TQV_SLOT_WORD));
    assign sel_byte = byte_space && (simple_slot == slot_t'(`TQV_SLOT_BYTE));

    // No new read reaches a target while a result sits in the buffer
    assign rd_req = i_rd_block ? ACC_NONE : i_rd_size;

    assign gpio_bus.offs    = offs;
    assign gpio_bus.wdata   = i_data_in;
    assign gpio_bus.wr_size = sel_gpio ? i_wr_size : ACC_NONE;
    assign gpio_bus.rd_size = sel_gpio ? rd_req : ACC_NONE;

    assign word_bus.offs    = offs;
    assign word_bus.wdata   = i_data_in;
    assign word_bus.wr_size = sel_word ? i_wr_size : ACC_NONE;
    assign word_bus.rd_size = sel_word ? rd_req : ACC_NONE;

    assign byte_bus.offs    = offs;
    assign byte_bus.wdata   = i_data_in;
    assign byte_bus.wr_size = sel_byte ? i_wr_size : ACC_NONE;
    assign byte_bus.rd_size = sel_byte ? rd_req : ACC_NONE;

    always_comb begin
        o_rdata    = '0;
        o_rd_ready = 1'b1;
        if (sel_gpio) begin
            o_rdata    = gpio_bus.rdata;
            o_rd_ready = gpio_bus.rd_ready;
        end else if (sel_word) begin
            o_rdata    = word_bus.rdata;
            o_rd_ready = word_bus.rd_ready;
        end else if (sel_byte) begin
            // Byte targets only return their low byte
            o_rdata    = {{(`TQV_DATA_W-8){1'b0}}, byte_bus.rdata[7:0]};
            o_rd_ready = byte_bus.rd_ready;
        end
    end

endmodule

/* periph_bus_if.sv */
`timescale 1ns/1ps
// Connection between the address decoder and one peripheral
// Requests arrive already qualified, an unselected target sees ACC_NONE
// Addresses never reach the peripheral, only the offset inside its slot

interface periph_bus_if;
    import tqv_periph_pkg::*;

    offs_t     offs;
    data_t     wdata;
    acc_size_e wr_size;
    acc_size_e rd_size;
    data_t     rdata;
    logic      rd_ready;

    // Decoder side
    modport ctrl (
        output offs,
        output wdata,
        output wr_size,
        output rd_size,
        input  rdata,
        input  rd_ready
    );

    // Peripheral side
    modport peri (
        input  offs,
        input  wdata,
        input  wr_size,
        input  rd_size,
        output rdata,
        output rd_ready
    );

endinterface

/* periph_trace.txt */
# op addr(hex) size(0=8 1=16 2=32) data(hex, write data or expected read) ui_in(hex)
# GPIO at 040, selects at 060+4n, word slot at 100, byte simple slot at 400
R 040 2 00000000 00
R 060 2 00000001 00
R 07c 2 00000001 00
R 100 2 00000000 00
R 10c 2 00000000 00
R 400 0 00000000 00
R 403 0 00000000 00
W 040 2 0000005a 00
R 040 2 0000005a 00
R 044 2 000000c3 c3
W 104 2 12345678 00
W 104 1 0000beef 00
W 104 0 000000a5 00
R 104 2 1234bea5 00
W 108 2 cafef00d 00
R 108 1 cafef00d 00
R 100 0 00000000 00
W 401 0 0000003c 00
W 400 2 ffffff96 00
R 401 0 0000003c 00
R 400 2 00000096 00
R 080 2 00000000 00
R 430 0 00000000 00
W 100 2 00000012 00
W 064 2 00000004 00
W 070 2 00000004 00
W 078 2 00000010 00
W 07c 2 00000010 00
W 068 2 00000002 00
R 064 2 00000004 00
R 07c 2 00000010 5e

/* read_data_buffer.sv */
`timescale 1ns/1ps
// Read result register between the peripherals and the core
// Data captured on the first ready cycle stays put until read complete
// Write acknowledge is combinational, read ready is one cycle late

module read_data_buffer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  tqv_periph_pkg::data_t     i_rdata,
    input  logic                      i_rd_ready,
    input  tqv_periph_pkg::acc_size_e i_rd_size,
    input  tqv_periph_pkg::acc_size_e i_wr_size,
    input  logic                      i_read_complete,
    output tqv_periph_pkg::data_t     o_data_out,
    output logic                      o_data_ready,
    output logic                      o_rd_block
);
    import tqv_periph_pkg::*;

    logic  read_req;
    logic  capture;
    logic  hold;
    logic  ready_q;
    data_t data_q;

    assign read_req = i_rd_size != ACC_NONE;
    assign capture  = !hold && read_req && i_rd_ready && !i_read_complete;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end else if (capture) begin
                hold <= 1'b1;
            end
            // Ready of a finished read must not leak into the next request
            ready_q <= read_req && i_rd_ready && !i_read_complete;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rdata;
        end
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || (i_wr_size != ACC_NONE);
    assign o_rd_block   = ready_q;

endmodule

/* tb_tqv_peripherals.sv */
`timescale 1ns/1ps
// Trace-driven testbench for the peripheral wrapper
// Reads periph_trace.txt from the project root, one bus operation per line
// Pin outputs are predicted from a shadow of GPIO out, the selects and register 0

`include "tqv_periph_cfg.svh"

module tb_tqv_peripherals;
    import tqv_periph_pkg::*;

    localparam int    READY_TIMEOUT = 16;
    localparam string TRACE_FILE    = "periph_trace.txt";

    logic      clk;
    logic      rst_n;
    pins_t     ui_in;
    addr_t     addr;
    data_t     data_in;
    acc_size_e write_n;
    acc_size_e read_n;
    logic      read_complete;
    pins_t     uo_out;
    data_t     data_out;
    logic      data_ready;

    // Shadow of everything that decides the pin outputs
    pins_t     sh_gpio_out;
    func_sel_t sh_sel [`TQV_PINS];
    pins_t     sh_word0;
    pins_t     sh_byte0;

    tqv_peripherals u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .i_addr               (addr),
        .i_data_in            (data_in),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .i_data_read_complete (read_complete),
        .o_uo_out             (uo_out),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0d ns: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    // Word space: bits 9:6 slot, byte space: bits 7:4 simple slot
    function automatic void update_shadow(input addr_t a, input data_t d);
        offs_t      offs;
        offs_t      rel;
        logic [2:0] pin;
        offs = a[`TQV_OFFS_W-1:0];
        rel  = offs - offs_t'(`TQV_GPIO_SEL_BASE);
        pin  = rel[4:2];
        if (!a[`TQV_ADDR_W-1]) begin
            if (a[9:6] == slot_t'(`TQV_SLOT_GPIO)) begin
                if (offs == offs_t'(`TQV_GPIO_OUT_OFFS)) begin
                    sh_gpio_out = d[`TQV_PINS-1:0];
                end else if (offs >= offs_t'(`TQV_GPIO_SEL_BASE) && offs[1:0] == 2'b00) begin
                    sh_sel[pin] = d[`TQV_FUNC_SIMPLE_BIT:0];
                end
            end else if (a[9:6] == slot_t'(`TQV_SLOT_WORD) && offs[3:2] == 2'b00) begin
                // Any write size covers the low byte of the register
                sh_word0 = d[7:0];
            end
        end else if (a[7:4] == slot_t'(`TQV_SLOT_BYTE) && offs[1:0] == 2'b00) begin
            sh_byte0 = d[7:0];
        end
    endfunction

    function automatic pins_t expected_pins();
        pins_t p;
        for (int n = 0; n < `TQV_PINS; n++) begin
            if (sh_sel[n] == func_sel_t'(`TQV_SLOT_GPIO)) begin
                p[n] = sh_gpio_out[n];
            end else if (sh_sel[n] == func_sel_t'(`TQV_SLOT_WORD)) begin
                p[n] = sh_word0[n];
            end else if (sh_sel[n] ==
                         func_sel_t'((1 << `TQV_FUNC_SIMPLE_BIT) | `TQV_SLOT_BYTE)) begin
                p[n] = sh_byte0[n];
            end else begin
                p[n] = 1'b0;
            end
        end
        return p;
    endfunction

    task automatic issue_write(input addr_t a, input acc_size_e sz,
                               input data_t d, input pins_t ui);
        @(posedge clk);
        addr    <= a;
        data_in <= d;
        write_n <= sz;
        ui_in   <= ui;
        @(negedge clk);
        check_value("o_data_ready", data_t'(data_ready), data_t'(1));
        @(posedge clk);
        write_n <= ACC_NONE;
        update_shadow(a, d);
    endtask

    // Holds the request past ready for a few random cycles, then completes
    task automatic read_and_hold(input addr_t a, input acc_size_e sz,
                                 input data_t exp, input pins_t ui);
        int    waited;
        int    hold_cycles;
        @(posedge clk);
        addr   <= a;
        read_n <= sz;
        ui_in  <= ui;
        waited = 0;
        @(negedge clk);
        while (data_ready !== 1'b1) begin
            if (waited >= READY_TIMEOUT) begin
                fail_run($sformatf("Read of address %h never became ready", a));
            end
            waited++;
            @(negedge clk);
        end
        check_value("o_data_out", data_out, exp);
        hold_cycles = $urandom_range(4, 1);
        for (int i = 0; i < hold_cycles; i++) begin
            @(negedge clk);
            check_value("o_data_out", data_out, exp);
        end
        @(posedge clk);
        read_n        <= ACC_NONE;
        read_complete <= 1'b1;
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    initial begin
        int         fd;
        int         fields;
        string      line;
        logic [7:0] op;
        addr_t      a;
        logic [1:0] sz;
        data_t      d;
        pins_t      ui;

        clk           = 1'b0;
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        data_in       = '0;
        write_n       = ACC_NONE;
        read_n        = ACC_NONE;
        read_complete = 1'b0;
        sh_gpio_out   = '0;
        sh_word0      = '0;
        sh_byte0      = '0;
        for (int n = 0; n < `TQV_PINS; n++) begin
            sh_sel[n] = func_sel_t'(`TQV_SLOT_GPIO);
        end
        void'($urandom(32'h2348));

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("o_uo_out", data_t'(uo_out), data_t'(expected_pins()));

        // Every select and every example register comes out of reset clean
        for (int n = 0; n < `TQV_PINS; n++) begin
            read_and_hold(addr_t'({1'b0, slot_t'(`TQV_SLOT_GPIO),
                                   offs_t'(`TQV_GPIO_SEL_BASE + 4 * n)}),
                          ACC_WORD, data_t'(sh_sel[n]), '0);
        end
        for (int r = 0; r < 4; r++) begin
            read_and_hold(addr_t'({1'b0, slot_t'(`TQV_SLOT_WORD), offs_t'(4 * r)}),
                          ACC_WORD, '0, '0);
            read_and_hold(addr_t'({1'b1, 2'b00, slot_t'(`TQV_SLOT_BYTE), 4'(r)}),
                          ACC_BYTE, '0, '0);
        end

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            fail_run("Could not open the trace file periph_trace.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h", op, a, sz, d, ui);
            if (fields != 5) begin
                fail_run($sformatf("Trace line is malformed: %s", line));
            end
            repeat ($urandom_range(3, 0)) @(posedge clk);
            if (op == "W") begin
                issue_write(a, acc_size_e'(sz), d, ui);
            end else if (op == "R") begin
                read_and_hold(a, acc_size_e'(sz), d, ui);
            end else begin
                fail_run($sformatf("Trace line has an unknown operation: %s", line));
            end
            @(negedge clk);
            check_value("o_uo_out", data_t'(uo_out), data_t'(expected_pins()));
        end
        $fclose(fd);

        // Pins routed away from GPIO must not follow a change of the GPIO register
        issue_write(addr_t'({1'b0, slot_t'(`TQV_SLOT_GPIO), offs_t'(`TQV_GPIO_OUT_OFFS)}),
                    ACC_WORD, data_t'(~sh_gpio_out), '0);
        @(negedge clk);
        check_value("o_uo_out", data_t'(uo_out), data_t'(expected_pins()));

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* tqv_periph_cfg.svh */
// Sizes, slot numbers and register offsets of the peripheral bus
// Offsets are byte offsets inside a 64-byte user slot
// Only the slots named here hold a peripheral, the rest read as zero

`ifndef TQV_PERIPH_CFG_SVH
`define TQV_PERIPH_CFG_SVH

`define TQV_ADDR_W          11
`define TQV_DATA_W          32
`define TQV_OFFS_W          6
`define TQV_PINS            8
`define TQV_SLOTS           16

`define TQV_SLOT_GPIO       1
`define TQV_SLOT_WORD       4
`define TQV_SLOT_BYTE       0

`define TQV_GPIO_OUT_OFFS   'h00
`define TQV_GPIO_IN_OFFS    'h04
`define TQV_GPIO_SEL_BASE   'h20
`define TQV_FUNC_SIMPLE_BIT 4

`endif

/* tqv_periph_pkg.sv */
// Shared types of the peripheral bus
// Access size codes follow the core encoding, 11 means no access

`include "tqv_periph_cfg.svh"

package tqv_periph_pkg;

    typedef logic [`TQV_ADDR_W-1:0] addr_t;
    typedef logic [`TQV_DATA_W-1:0] data_t;
    typedef logic [`TQV_OFFS_W-1:0] offs_t;
    typedef logic [`TQV_PINS-1:0]   pins_t;

    // Top bit picks the simple space, low bits pick the slot
    typedef logic [`TQV_FUNC_SIMPLE_BIT:0] func_sel_t;

    typedef logic [$clog2(`TQV_SLOTS)-1:0] slot_t;

    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } acc_size_e;

endpackage

/* tqv_peripherals.sv */
`timescale 1ns/1ps
// Peripheral wrapper for the microcontroller core
// Holds GPIO in user slot 1, a word example in slot 4, a byte example in simple slot 0
// The core holds a read until o_data_ready and then pulses read complete

module tqv_peripherals (
    input  logic                      clk,
    input  logic                      rst_n,
    input  tqv_periph_pkg::pins_t     i_ui_in,
    input  tqv_periph_pkg::addr_t     i_addr,
    input  tqv_periph_pkg::data_t     i_data_in,
    input  tqv_periph_pkg::acc_size_e i_data_write_n,
    input  tqv_periph_pkg::acc_size_e i_data_read_n,
    input  logic                      i_data_read_complete,
    output tqv_periph_pkg::pins_t     o_uo_out,
    output tqv_periph_pkg::data_t     o_data_out,
    output logic                      o_data_ready
);
    import tqv_periph_pkg::*;

    data_t dec_rdata;
    logic  dec_rd_ready;
    logic  rd_block;
    pins_t word_pins;
    pins_t byte_pins;

    periph_bus_if gpio_bus ();
    periph_bus_if word_bus ();
    periph_bus_if byte_bus ();

    periph_addr_decode u_decode (
        .i_addr     (i_addr),
        .i_data_in  (i_data_in),
        .i_wr_size  (i_data_write_n),
        .i_rd_size  (i_data_read_n),
        .i_rd_block (rd_block),
        .o_rdata    (dec_rdata),
        .o_rd_ready (dec_rd_ready),
        .gpio_bus   (gpio_bus.ctrl),
        .word_bus   (word_bus.ctrl),
        .byte_bus   (byte_bus.ctrl)
    );

    gpio_func_ctrl u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ui_in     (i_ui_in),
        .i_word_pins (word_pins),
        .i_byte_pins (byte_pins),
        .o_uo_out    (o_uo_out),
        .bus         (gpio_bus.peri)
    );

    word_scratch_peri u_word (
        .clk    (clk),
        .rst_n  (rst_n),
        .o_pins (word_pins),
        .bus    (word_bus.peri)
    );

    byte_reg_peri u_byte (
        .clk    (clk),
        .rst_n  (rst_n),
        .o_pins (byte_pins),
        .bus    (byte_bus.peri)
    );

    read_data_buffer u_rbuf (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_rdata         (dec_rdata),
        .i_rd_ready      (dec_rd_ready),
        .i_rd_size       (i_data_read_n),
        .i_wr_size       (i_data_write_n),
        .i_read_complete (i_data_read_complete),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready),
        .o_rd_block      (rd_block)
    );

endmodule

/* word_scratch_peri.sv */
`timescale 1ns/1ps
// Example word peripheral, four 32-bit scratch registers at offsets 0..0xC
// Reads of any size return the whole register one cycle after the request
// Register 0 low byte drives the pins when a pin selects this slot

module word_scratch_peri (
    input  logic                  clk,
    input  logic                  rst_n,
    output tqv_periph_pkg::pins_t o_pins,
    periph_bus_if.peri            bus
);
    import tqv_periph_pkg::*;

    data_t      regs [4];
    logic [1:0] idx;
    logic       rd_req;
    logic       ready_q;
    offs_t      offs_q;
    data_t      rdata_q;

    assign idx    = bus.offs[3:2];
    assign rd_req = bus.rd_size != ACC_NONE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
            ready_q <= 1'b0;
        end else begin
            // Sized write replaces only the low bits
            case (bus.wr_size)
                ACC_BYTE: regs[idx][7:0]  <= bus.wdata[7:0];
                ACC_HALF: regs[idx][15:0] <= bus.wdata[15:0];
                ACC_WORD: regs[idx]       <= bus.wdata;
                default:  ;
            endcase
            ready_q <= rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            rdata_q <= regs[idx];
            offs_q  <= bus.offs;
        end
    end

    // Ready holds only for the offset it was sampled at, back-to-back reads stay safe
    assign bus.rd_ready = ready_q && (offs_q == bus.offs);
    assign bus.rdata    = rdata_q;
    assign o_pins       = regs[0][7:0];

endmodule
